//--- logic/ethFramePkg.sv
//------------------------------
// stream-side definitions
// beat and keep widths, byte lane,
// MAC header field types
//------------------------------

package ethFramePkg;

	// byte lanes per beat
	parameter int beatBytes = 16;

	// one data beat, lane k sits at bits 8k+7:8k
	typedef logic [beatBytes*8-1:0] beatT;

	// per-lane valid mask, contiguous from lane 0
	typedef logic [beatBytes-1:0] keepT;

	// a single byte lane
	typedef logic [7:0] laneT;

	//------------------------------
	// MAC header
	//------------------------------
	typedef logic [47:0] macAddrT;

	// frame type, 0x0800 for IPv4
	typedef logic [15:0] etherTypeT;

endpackage

//--- logic/ipv4Pkg.sv
//------------------------------
// IPv4 header definitions
// field types, accepted version/IHL,
// header size, realign offset,
// checksum accumulator, rx states
//------------------------------

package ipv4Pkg;

	//------------------------------
	// header field types
	//------------------------------
	typedef logic [3:0] ipNibbleT;
	typedef logic [5:0] ipDscpT;
	typedef logic [1:0] ipEcnT;
	typedef logic [15:0] ipWordT;
	typedef logic [2:0] ipFlagT;
	typedef logic [12:0] ipFragT;
	typedef logic [7:0] ipByteT;
	typedef logic [31:0] ipAddrT;

	// only plain IPv4 without options is supported
	parameter ipNibbleT ipv4Version = 4'd4;
	parameter ipNibbleT ipv4Ihl = 4'd5;

	// header length and how far the payload sits off lane 0
	parameter int ipHdrBytes = 20;
	parameter int realignBytes = ipHdrBytes % ethFramePkg::beatBytes;

	// ten 16-bit words plus carries
	typedef logic [19:0] cksumAccT;

	// receive states
	typedef enum logic [1:0] {
		idle,
		readHeader,
		readPayload
	} rxStateT;

endpackage

//--- logic/ipRxControl.sv
//------------------------------
// receive FSM
// header beat index, input ready
// terms, header output valid
//------------------------------

module ipRxControl (
	input logic wClk,
	input logic rst,
	input logic hdrInValid,
	input logic dataInValid,
	input logic lastOut,
	input logic dataOutReady,
	input logic hdrOutReady,
	input logic dataOutValid,
	input logic dropPacket,
	output logic hdrInReady,
	output logic dataInReady,
	output logic hdrOutValid,
	output ipv4Pkg::rxStateT state,
	output logic hdrIndex,
	output logic headerDone
);
	import ipv4Pkg::*;

	rxStateT stateNext;
	logic inXfer;
	logic lastDone;
	// header waiting for the downstream side
	logic hdrPending;

	// a header is only taken between packets
	assign hdrInReady = (state == idle) && hdrInValid;
	// a dropped packet never shows its header
	assign hdrOutValid = hdrPending && !dropPacket;
	// any output stall holds the input
	assign dataInReady = (state != idle) && dataOutReady && (hdrOutReady || !hdrOutValid);
	assign inXfer = dataInValid && dataInReady;
	// second header beat accepted
	assign headerDone = (state == readHeader) && hdrIndex && inXfer;
	// final beat gone, either shown or silently consumed
	assign lastDone = lastOut && dataOutReady && (dataOutValid || dropPacket);

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (hdrInReady) begin
					stateNext = readHeader;
				end
			end
			readHeader: begin
				if (headerDone) begin
					stateNext = readPayload;
				end
			end
			readPayload: begin
				if (lastDone) begin
					stateNext = idle;
				end
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge wClk) begin
		if (rst) begin
			state <= idle;
			hdrIndex <= 1'b0;
			hdrPending <= 1'b0;
		end else begin
			state <= stateNext;
			// beat 0 then beat 1, wraps back for the next packet
			if ((state == readHeader) && inXfer) begin
				hdrIndex <= !hdrIndex;
			end
			// drop or return to idle also retires the pending header
			if (headerDone) begin
				hdrPending <= 1'b1;
			end else if ((hdrOutValid && hdrOutReady) || dropPacket || (state == idle)) begin
				hdrPending <= 1'b0;
			end
		end
	end

endmodule

//--- logic/ipHeaderExtract.sv
//------------------------------
// MAC header capture
// IPv4 field capture from beats 0/1
// header checksum and packet verdict
//------------------------------

module ipHeaderExtract (
	input logic wClk,
	input logic rst,
	input logic hdrInValid,
	input logic hdrInReady,
	input ethFramePkg::macAddrT hdrInDstMac,
	input ethFramePkg::macAddrT hdrInSrcMac,
	input ethFramePkg::etherTypeT hdrInEtherType,
	input ethFramePkg::beatT dataIn,
	input logic dataInValid,
	input logic dataInReady,
	input ipv4Pkg::rxStateT state,
	input logic hdrIndex,
	input logic headerDone,
	output ethFramePkg::macAddrT hdrOutDstMac,
	output ethFramePkg::macAddrT hdrOutSrcMac,
	output ethFramePkg::etherTypeT hdrOutEtherType,
	output ipv4Pkg::ipNibbleT ipVersion,
	output ipv4Pkg::ipNibbleT ipIhl,
	output ipv4Pkg::ipDscpT ipDscp,
	output ipv4Pkg::ipEcnT ipEcn,
	output ipv4Pkg::ipWordT ipLength,
	output ipv4Pkg::ipWordT ipIdent,
	output ipv4Pkg::ipFlagT ipFlag,
	output ipv4Pkg::ipFragT ipFragOffset,
	output ipv4Pkg::ipByteT ipTtl,
	output ipv4Pkg::ipByteT ipProtocol,
	output ipv4Pkg::ipWordT ipChecksum,
	output ipv4Pkg::ipAddrT ipSrcAddr,
	output ipv4Pkg::ipAddrT ipDstAddr,
	output logic unsupportedHit,
	output logic badChecksumHit
);
	import ethFramePkg::*;
	import ipv4Pkg::*;

	logic beat0Take;
	cksumAccT cksumAcc;
	cksumAccT beat0Sum;
	cksumAccT cksumTotal;
	logic [16:0] cksumFold;
	ipWordT cksumFinal;

	// header word idx, the even byte is the high half
	function automatic ipWordT hdrWord(beatT beat, int idx);
		laneT hiByte;
		laneT loByte;
		hiByte = beat[16*idx +: 8];
		loByte = beat[16*idx+8 +: 8];
		return {hiByte, loByte};
	endfunction

	assign beat0Take = (state == readHeader) && !hdrIndex && dataInValid && dataInReady;

	//------------------------------
	// field capture
	//------------------------------
	always_ff @(posedge wClk) begin
		if (hdrInValid && hdrInReady) begin
			hdrOutDstMac <= hdrInDstMac;
			hdrOutSrcMac <= hdrInSrcMac;
			hdrOutEtherType <= hdrInEtherType;
		end
		// multi-byte fields keep the raw lane order
		if (beat0Take) begin
			ipVersion <= dataIn[3:0];
			ipIhl <= dataIn[7:4];
			ipDscp <= dataIn[13:8];
			ipEcn <= dataIn[15:14];
			ipLength <= dataIn[31:16];
			ipIdent <= dataIn[47:32];
			ipFlag <= dataIn[50:48];
			ipFragOffset <= dataIn[63:51];
			ipTtl <= dataIn[71:64];
			ipProtocol <= dataIn[79:72];
			ipChecksum <= dataIn[95:80];
			ipSrcAddr <= dataIn[127:96];
		end
		// beat 1 lanes 0..3 hold the destination
		if (headerDone) begin
			ipDstAddr <= dataIn[31:0];
		end
	end

	//------------------------------
	// checksum
	//------------------------------
	// eight words of beat 0 in one go
	always_comb begin
		beat0Sum = '0;
		for (int k = 0; k < 8; k++) begin
			beat0Sum = beat0Sum + cksumAccT'(hdrWord(dataIn, k));
		end
	end

	always_ff @(posedge wClk) begin
		if (rst) begin
			cksumAcc <= '0;
		end else if (beat0Take) begin
			cksumAcc <= beat0Sum;
		end
	end

	// add the two destination words, then fold the carries twice
	// a pre-fold total of 0x1FFFE also ends at 0xFFFF here
	assign cksumTotal = cksumAcc + hdrWord(dataIn, 0) + hdrWord(dataIn, 1);
	assign cksumFold = cksumTotal[15:0] + cksumTotal[19:16];
	assign cksumFinal = cksumFold[15:0] + cksumFold[16];
	assign badChecksumHit = (cksumFinal != 16'hFFFF);

	// version and IHL were captured a beat earlier
	assign unsupportedHit = (ipVersion != ipv4Version) || (ipIhl != ipv4Ihl);

endmodule

//--- logic/ipDropStats.sv
//------------------------------
// drop level for the packet
// in flight, unsupported and
// bad-checksum counters
//------------------------------

module ipDropStats #(
	parameter int statWidth = 32
) (
	input logic wClk,
	input logic rst,
	input logic headerDone,
	input logic unsupportedHit,
	input logic badChecksumHit,
	input logic lastOut,
	input logic dataOutReady,
	output logic dropPacket,
	output logic [statWidth-1:0] unsupportedCount,
	output logic [statWidth-1:0] badChecksumCount
);

	//------------------------------
	// statistics
	//------------------------------
	// both counters may step for the same packet
	always_ff @(posedge wClk) begin
		if (rst) begin
			unsupportedCount <= '0;
			badChecksumCount <= '0;
		end else if (headerDone) begin
			if (unsupportedHit) begin
				unsupportedCount <= unsupportedCount + 1'b1;
			end
			if (badChecksumHit) begin
				badChecksumCount <= badChecksumCount + 1'b1;
			end
		end
	end

	// held from the verdict until the last beat is consumed
	always_ff @(posedge wClk) begin
		if (rst) begin
			dropPacket <= 1'b0;
		end else if (headerDone) begin
			dropPacket <= unsupportedHit || badChecksumHit;
		end else if (lastOut && dataOutReady) begin
			dropPacket <= 1'b0;
		end
	end

endmodule

//--- logic/payloadRealign.sv
//------------------------------
// payload realign by four bytes
// keep shift, extra tail beat,
// payload valid and last
//------------------------------

module payloadRealign (
	input logic wClk,
	input logic rst,
	input ethFramePkg::beatT dataIn,
	input ethFramePkg::keepT keepIn,
	input logic lastIn,
	input logic dataInValid,
	input logic dataInReady,
	input logic hdrOutValid,
	input logic hdrOutReady,
	input logic dataOutReady,
	input logic dropPacket,
	output ethFramePkg::beatT dataOut,
	output ethFramePkg::keepT keepOut,
	output logic lastOut,
	output logic dataOutValid
);
	import ethFramePkg::*;
	import ipv4Pkg::*;

	localparam int shiftBits = realignBytes * 8;

	beatT heldData;
	keepT heldKeep;
	logic [2*beatBytes*8-1:0] joinData;
	logic [2*beatBytes-1:0] joinKeep;
	logic inXfer;
	logic hdrXfer;
	logic phaseOpen;
	logic extraGo;
	logic loadOut;
	logic upperLanes;
	logic extraPending;
	logic outFull;
	logic payActive;
	logic lastReg;

	assign inXfer = dataInValid && dataInReady;
	assign hdrXfer = hdrOutValid && hdrOutReady;
	// payload phase, shown or dropped
	assign phaseOpen = payActive || dropPacket || hdrXfer;
	// tail beat leaves once the slot frees up
	assign extraGo = extraPending && dataOutReady && phaseOpen;
	assign loadOut = inXfer || extraGo;
	// bytes past lane 3 spill into one more beat
	assign upperLanes = (keepIn >> realignBytes) != '0;
	assign joinData = {dataIn, heldData} >> shiftBits;
	assign joinKeep = {keepIn, heldKeep} >> realignBytes;

	always_ff @(posedge wClk) begin
		if (inXfer) begin
			heldData <= dataIn;
			heldKeep <= keepIn;
		end
		// held bytes 4..15, then current bytes 0..3
		if (extraGo) begin
			dataOut <= heldData >> shiftBits;
			keepOut <= heldKeep >> realignBytes;
		end else if (inXfer) begin
			dataOut <= joinData[beatBytes*8-1:0];
			keepOut <= joinKeep[beatBytes-1:0];
		end
	end

	always_ff @(posedge wClk) begin
		if (rst) begin
			extraPending <= 1'b0;
			lastReg <= 1'b0;
			outFull <= 1'b0;
			payActive <= 1'b0;
		end else begin
			if (extraGo) begin
				extraPending <= 1'b0;
				lastReg <= 1'b1;
			end else if (inXfer) begin
				extraPending <= lastIn && upperLanes;
				lastReg <= lastIn && !upperLanes;
			end
			// header beats reload the register but never fill it
			if (loadOut && phaseOpen) begin
				outFull <= 1'b1;
			end else if (dataOutReady) begin
				outFull <= 1'b0;
			end
			if (hdrXfer) begin
				payActive <= 1'b1;
			end else if (lastOut && dataOutValid && dataOutReady) begin
				payActive <= 1'b0;
			end
		end
	end

	assign dataOutValid = payActive && outFull;
	assign lastOut = lastReg && outFull;

endmodule

//--- logic/ipRxTop.sv
//------------------------------
// IPv4 receive top level
// FSM, header extract, drop
// statistics and payload realign
//------------------------------

module ipRxTop #(
	parameter int statWidth = 32
) (
	input logic wClk,
	input logic rst,
	// header in
	input logic hdrInValid,
	output logic hdrInReady,
	input ethFramePkg::macAddrT hdrInDstMac,
	input ethFramePkg::macAddrT hdrInSrcMac,
	input ethFramePkg::etherTypeT hdrInEtherType,
	// data in
	input logic dataInValid,
	output logic dataInReady,
	input ethFramePkg::beatT dataIn,
	input ethFramePkg::keepT keepIn,
	input logic lastIn,
	// header out
	output logic hdrOutValid,
	input logic hdrOutReady,
	output ethFramePkg::macAddrT hdrOutDstMac,
	output ethFramePkg::macAddrT hdrOutSrcMac,
	output ethFramePkg::etherTypeT hdrOutEtherType,
	output ipv4Pkg::ipNibbleT ipVersion,
	output ipv4Pkg::ipNibbleT ipIhl,
	output ipv4Pkg::ipDscpT ipDscp,
	output ipv4Pkg::ipEcnT ipEcn,
	output ipv4Pkg::ipWordT ipLength,
	output ipv4Pkg::ipWordT ipIdent,
	output ipv4Pkg::ipFlagT ipFlag,
	output ipv4Pkg::ipFragT ipFragOffset,
	output ipv4Pkg::ipByteT ipTtl,
	output ipv4Pkg::ipByteT ipProtocol,
	output ipv4Pkg::ipWordT ipChecksum,
	output ipv4Pkg::ipAddrT ipSrcAddr,
	output ipv4Pkg::ipAddrT ipDstAddr,
	// payload out
	output logic dataOutValid,
	input logic dataOutReady,
	output ethFramePkg::beatT dataOut,
	output ethFramePkg::keepT keepOut,
	output logic lastOut,
	// statistics
	output logic [statWidth-1:0] unsupportedCount,
	output logic [statWidth-1:0] badChecksumCount
);
	import ipv4Pkg::*;

	rxStateT state;
	logic hdrIndex;
	logic headerDone;
	logic unsupportedHit;
	logic badChecksumHit;
	logic dropPacket;

	ipRxControl ipRxControl_inst (
		.wClk(wClk),
		.rst(rst),
		.hdrInValid(hdrInValid),
		.dataInValid(dataInValid),
		.lastOut(lastOut),
		.dataOutReady(dataOutReady),
		.hdrOutReady(hdrOutReady),
		.dataOutValid(dataOutValid),
		.dropPacket(dropPacket),
		.hdrInReady(hdrInReady),
		.dataInReady(dataInReady),
		.hdrOutValid(hdrOutValid),
		.state(state),
		.hdrIndex(hdrIndex),
		.headerDone(headerDone)
	);

	ipHeaderExtract ipHeaderExtract_inst (
		.wClk(wClk),
		.rst(rst),
		.hdrInValid(hdrInValid),
		.hdrInReady(hdrInReady),
		.hdrInDstMac(hdrInDstMac),
		.hdrInSrcMac(hdrInSrcMac),
		.hdrInEtherType(hdrInEtherType),
		.dataIn(dataIn),
		.dataInValid(dataInValid),
		.dataInReady(dataInReady),
		.state(state),
		.hdrIndex(hdrIndex),
		.headerDone(headerDone),
		.hdrOutDstMac(hdrOutDstMac),
		.hdrOutSrcMac(hdrOutSrcMac),
		.hdrOutEtherType(hdrOutEtherType),
		.ipVersion(ipVersion),
		.ipIhl(ipIhl),
		.ipDscp(ipDscp),
		.ipEcn(ipEcn),
		.ipLength(ipLength),
		.ipIdent(ipIdent),
		.ipFlag(ipFlag),
		.ipFragOffset(ipFragOffset),
		.ipTtl(ipTtl),
		.ipProtocol(ipProtocol),
		.ipChecksum(ipChecksum),
		.ipSrcAddr(ipSrcAddr),
		.ipDstAddr(ipDstAddr),
		.unsupportedHit(unsupportedHit),
		.badChecksumHit(badChecksumHit)
	);

	ipDropStats #(
		.statWidth(statWidth)
	) ipDropStats_inst (
		.wClk(wClk),
		.rst(rst),
		.headerDone(headerDone),
		.unsupportedHit(unsupportedHit),
		.badChecksumHit(badChecksumHit),
		.lastOut(lastOut),
		.dataOutReady(dataOutReady),
		.dropPacket(dropPacket),
		.unsupportedCount(unsupportedCount),
		.badChecksumCount(badChecksumCount)
	);

	payloadRealign payloadRealign_inst (
		.wClk(wClk),
		.rst(rst),
		.dataIn(dataIn),
		.keepIn(keepIn),
		.lastIn(lastIn),
		.dataInValid(dataInValid),
		.dataInReady(dataInReady),
		.hdrOutValid(hdrOutValid),
		.hdrOutReady(hdrOutReady),
		.dataOutReady(dataOutReady),
		.dropPacket(dropPacket),
		.dataOut(dataOut),
		.keepOut(keepOut),
		.lastOut(lastOut),
		.dataOutValid(dataOutValid)
	);

endmodule

//--- tests/ipRxTb_assert.sv
//------------------------------
// protocol assertions on the
// receive top outputs, bound
// into ipRxTop
//------------------------------

module ipRxAssert (
	input logic wClk,
	input logic rst,
	input logic hdrOutValid,
	input logic hdrOutReady,
	input logic dataOutValid,
	input logic dataOutReady,
	input ethFramePkg::beatT dataOut,
	input logic lastOut,
	input logic dropPacket
);
	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0;

	// header offer stays up until it is taken
	hdrHold: assert property (@(posedge wClk) disable iff (rst)
		hdrOutValid && !hdrOutReady |=> hdrOutValid)
		else begin
			$error("hdrOutValid fell before its transfer");
			assertFails++;
		end

	// payload beat holds valid and data while stalled
	dataHold: assert property (@(posedge wClk) disable iff (rst)
		dataOutValid && !dataOutReady |=> dataOutValid && $stable(dataOut))
		else begin
			$error("payload beat changed before its transfer");
			assertFails++;
		end

	// a dropped packet drains its last beat unseen
	lastFrame: assert property (@(posedge wClk) disable iff (rst)
		!dataOutValid && !dropPacket |-> !lastOut)
		else begin
			$error("lastOut high without dataOutValid");
			assertFails++;
		end

	// first reset edge only clears the registers
	resetQuiet: assert property (@(posedge wClk)
		rst && $past(rst) |-> !hdrOutValid && !dataOutValid)
		else begin
			$error("output valid high during reset");
			assertFails++;
		end

endmodule

bind ipRxTop ipRxAssert protocolCheck (
	.wClk(wClk),
	.rst(rst),
	.hdrOutValid(hdrOutValid),
	.hdrOutReady(hdrOutReady),
	.dataOutValid(dataOutValid),
	.dataOutReady(dataOutReady),
	.dataOut(dataOut),
	.lastOut(lastOut),
	.dropPacket(dropPacket)
);

//--- tests/ipRxTb.sv
//------------------------------
// testbench for the IPv4 receive top
// clock, reset, packet builder,
// output monitor, ready stalls,
// directed tests, compare tasks,
// watchdog
//------------------------------

module ipRxTb;
	timeunit 1ns;
	timeprecision 1ps;
	import ethFramePkg::*;
	import ipv4Pkg::*;

	localparam int statWidth = 32;
	localparam int numTests = 6;
	localparam int cycleNs = 20;

	// what one packet should look like at the header output
	typedef struct packed {
		macAddrT dstMac;
		macAddrT srcMac;
		etherTypeT etherType;
		ipNibbleT version;
		ipNibbleT ihl;
		ipByteT ecnDscp;
		ipWordT length;
		ipWordT ident;
		ipWordT flagFrag;
		ipByteT ttl;
		ipByteT protocol;
		ipWordT checksum;
		ipAddrT srcAddr;
		ipAddrT dstAddr;
	} hdrInfoT;

	logic wClk;
	logic rst;
	logic hdrInValid, hdrInReady;
	macAddrT hdrInDstMac, hdrInSrcMac;
	etherTypeT hdrInEtherType;
	logic dataInValid, dataInReady, lastIn;
	beatT dataIn;
	keepT keepIn;
	logic hdrOutValid, hdrOutReady;
	macAddrT hdrOutDstMac, hdrOutSrcMac;
	etherTypeT hdrOutEtherType;
	ipNibbleT ipVersion, ipIhl;
	ipDscpT ipDscp;
	ipEcnT ipEcn;
	ipWordT ipLength, ipIdent, ipChecksum;
	ipFlagT ipFlag;
	ipFragT ipFragOffset;
	ipByteT ipTtl, ipProtocol;
	ipAddrT ipSrcAddr, ipDstAddr;
	logic dataOutValid, dataOutReady, lastOut;
	beatT dataOut;
	keepT keepOut;
	logic [statWidth-1:0] unsupportedCount, badChecksumCount;

	integer seed = 85194;
	int holdLeft = 0;
	bit stallOn = 1'b0;

	// every packet sent, and only the ones that should come out
	hdrInfoT pktQ[$];
	hdrInfoT hdrExpQ[$];
	beatT inBeatQ[$];
	keepT inKeepQ[$];
	bit inLastQ[$];
	beatT outBeatQ[$];
	keepT outKeepQ[$];
	bit outLastQ[$];

	ipRxTop #(
		.statWidth(statWidth)
	) ipRxTop_inst (.*);

	initial begin
		wClk = 1'b0;
		forever begin
			#(cycleNs / 2) wClk = ~wClk;
		end
	end

	//------------------------------
	// compare tasks
	//------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkBeat(input string name, input beatT got, input beatT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkKeep(input string name, input keepT got, input keepT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkIpAddr(input string name, input ipAddrT got, input ipAddrT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkWord(input string name, input ipWordT got, input ipWordT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkNibble(input string name, input ipNibbleT got, input ipNibbleT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkByte(input string name, input ipByteT got, input ipByteT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkMac(input string name, input macAddrT got, input macAddrT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkCount(input string name, input logic [statWidth-1:0] got,
		input logic [statWidth-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	// byte mask of the lanes a keep marks valid
	function automatic beatT laneMask(input keepT keep);
		beatT mask;
		mask = '0;
		for (int k = 0; k < beatBytes; k++) begin
			if (keep[k]) begin
				mask[8*k +: 8] = 8'hFF;
			end
		end
		return mask;
	endfunction

	//------------------------------
	// packet builder
	//------------------------------
	task automatic buildPacket(input ipNibbleT ver, input bit corrupt, input int payLen);
		logic [7:0] bytes[$];
		hdrInfoT info;
		int sum;
		int start;
		ipWordT csum;
		beatT beat;
		keepT keep;
		bit shown;
		shown = (ver == 4'd4) && !corrupt;
		info.dstMac = {16'h0200, $random(seed)};
		info.srcMac = {16'h0600, $random(seed)};
		info.etherType = 16'h0800;
		info.length = ipWordT'(20 + payLen);
		info.srcAddr = $random(seed);
		info.dstAddr = $random(seed);
		// version low nibble, IHL 5 high nibble, DSCP 0x38 and ECN 2
		bytes.push_back({4'd5, ver});
		bytes.push_back(8'hB8);
		// multi-byte fields go in raw lane order
		bytes.push_back(info.length[7:0]);
		bytes.push_back(info.length[15:8]);
		bytes.push_back(8'h34);
		bytes.push_back(8'h12);
		// flags 2, fragment offset 0
		bytes.push_back(8'h02);
		bytes.push_back(8'h00);
		bytes.push_back(8'h40);
		bytes.push_back(8'h11);
		// checksum slot, filled below
		bytes.push_back(8'h00);
		bytes.push_back(8'h00);
		for (int k = 0; k < 4; k++) begin
			bytes.push_back(info.srcAddr[8*k +: 8]);
		end
		for (int k = 0; k < 4; k++) begin
			bytes.push_back(info.dstAddr[8*k +: 8]);
		end
		// ones' complement sum, byte 2k is the high half of word k
		sum = 0;
		for (int k = 0; k < 10; k++) begin
			sum += {bytes[2*k], bytes[2*k+1]};
		end
		while (sum > 32'hFFFF) begin
			sum = (sum & 32'hFFFF) + (sum >> 16);
		end
		csum = ~ipWordT'(sum);
		if (corrupt) begin
			csum ^= 16'h0100;
		end
		bytes[10] = csum[15:8];
		bytes[11] = csum[7:0];
		// field outputs as raw lanes, lower byte in the low half
		info.version = ver;
		info.ihl = 4'd5;
		info.ecnDscp = bytes[1];
		info.ident = {bytes[5], bytes[4]};
		info.flagFrag = {bytes[7], bytes[6]};
		info.ttl = bytes[8];
		info.protocol = bytes[9];
		info.checksum = {bytes[11], bytes[10]};
		for (int k = 0; k < payLen; k++) begin
			bytes.push_back(8'($random(seed)));
		end
		pktQ.push_back(info);
		if (shown) begin
			hdrExpQ.push_back(info);
		end
		// pass 0 cuts input beats, pass 1 the expected payload from byte 20
		for (int pass = 0; pass < 2; pass++) begin
			start = (pass == 0) ? 0 : 20;
			for (int idx = start; idx < bytes.size(); idx += beatBytes) begin
				beat = '0;
				keep = '0;
				for (int k = 0; k < beatBytes && idx + k < bytes.size(); k++) begin
					beat[8*k +: 8] = bytes[idx+k];
					keep[k] = 1'b1;
				end
				if (pass == 0) begin
					inBeatQ.push_back(beat);
					inKeepQ.push_back(keep);
					inLastQ.push_back(idx + beatBytes >= bytes.size());
				end else if (shown) begin
					outBeatQ.push_back(beat);
					outKeepQ.push_back(keep);
					outLastQ.push_back(idx + beatBytes >= bytes.size());
				end
			end
		end
	endtask

	//------------------------------
	// stimulus and monitor
	//------------------------------
	task automatic sendPackets(input int count);
		hdrInfoT info;
		@(posedge wClk);
		#2;
		for (int p = 0; p < count; p++) begin
			info = pktQ.pop_front();
			hdrInValid = 1'b1;
			hdrInDstMac = info.dstMac;
			hdrInSrcMac = info.srcMac;
			hdrInEtherType = info.etherType;
			// header waits for the FSM to come back to idle
			@(negedge wClk);
			while (!hdrInReady) begin
				@(negedge wClk);
			end
			@(posedge wClk);
			#2;
			hdrInValid = 1'b0;
			do begin
				dataInValid = 1'b1;
				dataIn = inBeatQ.pop_front();
				keepIn = inKeepQ.pop_front();
				lastIn = inLastQ.pop_front();
				@(negedge wClk);
				while (!dataInReady) begin
					@(negedge wClk);
				end
				@(posedge wClk);
				#2;
			end while (!lastIn);
			dataInValid = 1'b0;
			lastIn = 1'b0;
		end
	endtask

	// wait until every expected header and beat has come out
	task automatic drainOutputs();
		while (hdrExpQ.size() != 0 || outBeatQ.size() != 0) begin
			@(posedge wClk);
		end
	endtask

	task automatic watchHeader();
		hdrInfoT exp;
		if (hdrOutValid && hdrExpQ.size() == 0) begin
			failRun("hdrOutValid went high although no header was expected");
		end else if (hdrOutValid && hdrOutReady) begin
			exp = hdrExpQ.pop_front();
			checkMac("hdrOutDstMac", hdrOutDstMac, exp.dstMac);
			checkMac("hdrOutSrcMac", hdrOutSrcMac, exp.srcMac);
			checkWord("hdrOutEtherType", hdrOutEtherType, exp.etherType);
			checkNibble("ipVersion", ipVersion, exp.version);
			checkNibble("ipIhl", ipIhl, exp.ihl);
			checkByte("ipEcn/ipDscp", {ipEcn, ipDscp}, exp.ecnDscp);
			checkWord("ipLength", ipLength, exp.length);
			checkWord("ipIdent", ipIdent, exp.ident);
			checkWord("ipFragOffset/ipFlag", {ipFragOffset, ipFlag}, exp.flagFrag);
			checkByte("ipTtl", ipTtl, exp.ttl);
			checkByte("ipProtocol", ipProtocol, exp.protocol);
			checkWord("ipChecksum", ipChecksum, exp.checksum);
			checkIpAddr("ipSrcAddr", ipSrcAddr, exp.srcAddr);
			checkIpAddr("ipDstAddr", ipDstAddr, exp.dstAddr);
		end
	endtask

	task automatic watchPayload();
		keepT expKeep;
		if (dataOutValid && outBeatQ.size() == 0) begin
			failRun("dataOutValid went high although no payload beat was expected");
		end else if (dataOutValid && dataOutReady) begin
			expKeep = outKeepQ.pop_front();
			checkKeep("keepOut", keepOut, expKeep);
			checkBeat("dataOut", dataOut & laneMask(expKeep), outBeatQ.pop_front());
			checkFlag("lastOut", lastOut, outLastQ.pop_front());
		end
	endtask

	// outputs are settled by the falling edge
	initial begin
		forever begin
			@(negedge wClk);
			if (ipRxTop_inst.protocolCheck.assertFails != 0) begin
				failRun("a protocol assertion on the outputs failed");
			end
			if (rst === 1'b0) begin
				watchHeader();
				watchPayload();
			end
		end
	end

	// ready levels, held in random stretches while stalling
	initial begin
		forever begin
			@(posedge wClk);
			#2;
			if (!stallOn) begin
				hdrOutReady = 1'b1;
				dataOutReady = 1'b1;
			end else if (holdLeft == 0) begin
				hdrOutReady = 1'($random(seed));
				dataOutReady = 1'($random(seed));
				holdLeft = $random(seed) & 7;
			end else begin
				holdLeft--;
			end
		end
	end

	//------------------------------
	// directed tests
	//------------------------------
	task automatic goodPacketTest();
		buildPacket(4'd4, 1'b0, 40);
		sendPackets(1);
		drainOutputs();
	endtask

	// 70 bytes in, last input beat spills past lane 3
	task automatic extraBeatTest();
		buildPacket(4'd4, 1'b0, 50);
		sendPackets(1);
		drainOutputs();
	endtask

	task automatic badChecksumTest();
		logic [statWidth-1:0] badBefore;
		badBefore = badChecksumCount;
		buildPacket(4'd4, 1'b1, 30);
		sendPackets(1);
		checkCount("badChecksumCount", badChecksumCount, badBefore + 1'b1);
		buildPacket(4'd4, 1'b0, 24);
		sendPackets(1);
		drainOutputs();
	endtask

	task automatic versionTest();
		logic [statWidth-1:0] unsBefore;
		logic [statWidth-1:0] badBefore;
		unsBefore = unsupportedCount;
		badBefore = badChecksumCount;
		buildPacket(4'd6, 1'b0, 30);
		sendPackets(1);
		checkCount("unsupportedCount", unsupportedCount, unsBefore + 1'b1);
		checkCount("badChecksumCount", badChecksumCount, badBefore);
	endtask

	task automatic stallTest();
		buildPacket(4'd4, 1'b0, 40);
		stallOn = 1'b1;
		sendPackets(1);
		drainOutputs();
		stallOn = 1'b0;
	endtask

	// with and without the extra tail beat
	task automatic backToBackTest();
		buildPacket(4'd4, 1'b0, 16);
		buildPacket(4'd4, 1'b0, 37);
		buildPacket(4'd4, 1'b0, 64);
		sendPackets(3);
		drainOutputs();
	endtask

	initial begin
		#(numTests * 400 * cycleNs);
		failRun("watchdog expired before all tests finished");
	end

	initial begin
		rst = 1'b1;
		hdrInValid = 1'b0;
		hdrInDstMac = '0;
		hdrInSrcMac = '0;
		hdrInEtherType = '0;
		dataInValid = 1'b0;
		dataIn = '0;
		keepIn = '0;
		lastIn = 1'b0;
		hdrOutReady = 1'b0;
		dataOutReady = 1'b0;
		repeat (3) @(posedge wClk);
		#2;
		rst = 1'b0;
		goodPacketTest();
		extraBeatTest();
		badChecksumTest();
		versionTest();
		stallTest();
		backToBackTest();
		// a few idle cycles so a stray beat still reaches the monitor
		repeat (4) @(posedge wClk);
		if (ipRxTop_inst.protocolCheck.assertFails == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			failRun("protocol assertions reported failures");
		end
	end

endmodule

//--- flist.f
logic/ethFramePkg.sv
logic/ipv4Pkg.sv
logic/ipRxControl.sv
logic/ipHeaderExtract.sv
logic/ipDropStats.sv
logic/payloadRealign.sv
logic/ipRxTop.sv
tests/ipRxTb_assert.sv
tests/ipRxTb.sv
